// File: cart_top.f
source/cart_cfg_pkg.sv
source/snes_bus_pkg.sv
source/mcu_cfg_regs.sv
source/address.sv
source/bus_cycle_ctrl.sv
source/cart_top.sv
verification/cart_top_props.sv
verification/cart_top_tb.sv

// File: Makefile
SRCS := $(wildcard source/*.sv verification/*.sv)

all: run

obj_dir/Vcart_top_tb: cart_top.f $(SRCS)
	verilator --binary --assert --top-module cart_top_tb -f cart_top.f

run: obj_dir/Vcart_top_tb
	@out="$$(./obj_dir/Vcart_top_tb)"; echo "$$out"; \
	echo "$$out" | grep -q '=== PASS ==='

clean:
	rm -rf obj_dir

.PHONY: all run clean

// File: verification/cart_top_tb.sv
module cart_top_tb
  import cart_cfg_pkg::*;
  import snes_bus_pkg::*;
();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int DRAIN_LIMIT = 20;  // Cycles allowed for the last responses

  typedef struct packed {
    logic     mem_v;
    mem_req_t req;
    logic     per_v;
    periph_e  per;
  } exp_t;

  logic        CLK = 1'b0;
  logic        rst_n;
  logic        cfg_wr_valid;
  cfg_wr_t     cfg_wr;
  logic        bus_valid;
  snes_cycle_t bus;
  logic        mem_req_valid;
  mem_req_t    mem_req;
  logic        periph_valid;
  periph_e     periph;

  integer    seed = 32'hb8548181;
  cart_cfg_t model_cfg;         // Config as the DUT should hold it
  exp_t      exp_q[$];          // One entry per issued bus cycle
  int        rd_idx = 0;        // Next entry for the checker
  exp_t      due = '0;
  logic      due_valid = 1'b0;  // Response expected this cycle
  int n_checks = 0;
  int n_mem_err = 0;
  int n_per_err = 0;
  int n_strobe_err = 0;
  int n_timeout = 0;

  always #10 CLK = ~CLK;

  cart_top UUT (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .cfg_wr_valid  (cfg_wr_valid),
    .cfg_wr        (cfg_wr),
    .bus_valid     (bus_valid),
    .bus           (bus),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .periph_valid  (periph_valid),
    .periph        (periph)
  );

  function automatic logic [31:0] next_rand();
    next_rand = $random(seed);
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Reference model
  ////////////////////////////////////////////////////////////////////////////

  function automatic exp_t predict(snes_cycle_t c, cart_cfg_t cf);
    exp_t        e;
    logic [7:0]  bank;
    logic [15:0] ofs;
    logic        rom;
    logic        sram;
    logic        msu;
    logic        r213f;
    logic        obc1;
    logic        cmd;
    logic [23:0] sram_ofs;
    logic [23:0] rom_ofs;
    bank     = c.addr[23:16];
    ofs      = c.addr[15:0];
    rom      = bank[6] | ofs[15];  // Banks 40+ or upper half
    sram     = 1'b0;
    sram_ofs = '0;
    rom_ofs  = '0;
    case (cf.mapper)
      MAPPER_HIROM, MAPPER_EXHIROM: begin
        sram     = ~bank[6] & bank[5] & ofs[14] & ofs[13] & ~ofs[15];
        sram_ofs = {6'd0, bank[4:0], ofs[12:0]};
        if (cf.mapper == MAPPER_HIROM) begin
          rom_ofs = {1'b0, c.addr[22:0]};
        end else begin
          rom_ofs = {1'b0, ~bank[7], c.addr[21:0]};  // Bank 80+ first
        end
      end
      MAPPER_LOROM: begin
        sram     = (bank[6:4] == 3'b111) & (bank[3:0] < 4'd14)
                   & (~ofs[15] | ~cf.rom_mask[21]);
        sram_ofs = {4'd0, bank[4:0], ofs[14:0]};
        rom_ofs  = {2'd0, bank[6:0], ofs[14:0]};  // A15 dropped
      end
      default: sram = 1'b0;  // No mapping
    endcase
    sram          = sram & cf.sram_mask[0];
    e.mem_v       = rom | sram;
    e.req.addr    = sram ? SAVERAM_BASE + (sram_ofs & cf.sram_mask) : rom_ofs & cf.rom_mask;
    e.req.write   = c.write;
    e.req.saveram = sram;
    msu   = cf.features[FEAT_MSU1] & ~bank[6] & (ofs >= 16'h2000) & (ofs <= 16'h2007);
    r213f = cf.features[FEAT_213F] & (c.pa == 8'h3F);
    obc1  = cf.features[FEAT_OBC1] & ~bank[6] & (ofs[15:11] == 5'b01111);
    cmd   = ~bank[6] & (ofs[15:9] == 7'b0010101);  // No feature gate
    e.per_v = msu | r213f | obc1 | cmd;
    if (msu) begin
      e.per = PERIPH_MSU;
    end else if (r213f) begin
      e.per = PERIPH_R213F;
    end else if (obc1) begin
      e.per = PERIPH_OBC1;
    end else if (cmd) begin
      e.per = PERIPH_SNESCMD;
    end else begin
      e.per = PERIPH_NONE;
    end
    return e;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Random stimulus
  ////////////////////////////////////////////////////////////////////////////

  // Biased toward SaveRAM banks, ROM halves and peripheral windows
  function automatic snes_cycle_t random_cycle();
    snes_cycle_t c;
    logic [31:0] r;
    logic [31:0] s;
    r = next_rand();
    s = next_rand();
    case (s[10:8])
      3'd0: c.addr = {r[23], 2'b01, r[20:16], 3'b011, r[12:0]};   // HiROM SaveRAM
      3'd1: c.addr = {r[23], 3'b111, r[19:16], r[15:0]};         // LoROM SaveRAM
      3'd2: c.addr = {r[23:16], 1'b1, r[14:0]};                  // Upper halves
      3'd3: c.addr = {r[23], 1'b1, r[21:0]};                     // Banks 40+
      3'd4: c.addr = {r[23], 1'b0, r[21:16], 13'h0400, r[2:0]};  // MSU1
      3'd5: c.addr = {r[23], 1'b0, r[21:16], 5'b01111, r[10:0]}; // OBC1
      3'd6: c.addr = {r[23], 1'b0, r[21:16], 7'b0010101, r[8:0]};
      default: c.addr = r[23:0];
    endcase
    c.pa    = (s[13:12] == 2'b00) ? 8'h3F : s[7:0];
    c.write = s[31];
    return c;
  endfunction

  function automatic cart_cfg_t random_cfg();
    cart_cfg_t   c;
    logic [31:0] r;
    logic [1:0]  m;
    r = next_rand();
    m = r[17:16];
    if (m == 2'd3) begin
      m = 2'd1;
    end
    c.mapper    = (r[19:18] == 2'b11) ? mapper_e'(r[22:20]) : mapper_e'({1'b0, m});
    c.rom_mask  = 24'hFFFFFF >> r[2:0];  // Bit 21 set for large ROMs only
    c.sram_mask = 24'h07FFFF >> r[5:3];
    c.features  = r[15:8];
    if (r[24:23] == 2'b00) begin
      c.sram_mask[0] = 1'b0;
    end
    return c;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // Drivers
  ////////////////////////////////////////////////////////////////////////////

  task automatic write_cfg(input cfg_op_e op, input logic [23:0] data);
    @(posedge CLK);
    cfg_wr_valid <= 1'b1;
    cfg_wr       <= '{op: op, data: data};
    bus_valid    <= 1'b0;
    case (op)  // Fields truncate like the register file
      CFG_OP_MAPPER:    model_cfg.mapper    = mapper_e'(data[2:0]);
      CFG_OP_ROM_MASK:  model_cfg.rom_mask  = data;
      CFG_OP_SRAM_MASK: model_cfg.sram_mask = data;
      default:          model_cfg.features  = data[7:0];
    endcase
  endtask

  task automatic program_cfg(input cart_cfg_t c);
    logic [31:0] r;
    r = next_rand();  // Junk above the narrow fields
    write_cfg(CFG_OP_MAPPER, {r[23:3], c.mapper});
    write_cfg(CFG_OP_ROM_MASK, c.rom_mask);
    write_cfg(CFG_OP_SRAM_MASK, c.sram_mask);
    write_cfg(CFG_OP_FEATURES, {r[23:8], c.features});
  endtask

  task automatic drive_cycle(input snes_cycle_t c);
    @(posedge CLK);
    bus_valid    <= 1'b1;
    bus          <= c;
    cfg_wr_valid <= 1'b0;
    exp_q.push_back(predict(c, model_cfg));
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(posedge CLK);
      bus_valid    <= 1'b0;
      cfg_wr_valid <= 1'b0;
    end
  endtask

  // Random gaps and an optional config write right before a cycle
  task automatic run_cycles(input int n, input logic with_writes);
    logic [31:0] r;
    cart_cfg_t   rc;
    for (int i = 0; i < n; i++) begin
      r  = next_rand();
      rc = random_cfg();
      if (with_writes && r[5:4] == 2'b00) begin
        case (r[9:8])
          2'd0: write_cfg(CFG_OP_MAPPER, {r[31:11], rc.mapper});
          2'd1: write_cfg(CFG_OP_ROM_MASK, rc.rom_mask);
          2'd2: write_cfg(CFG_OP_SRAM_MASK, rc.sram_mask);
          default: write_cfg(CFG_OP_FEATURES, {r[31:16], rc.features});
        endcase
      end
      drive_cycle(random_cycle());
      if (r[1:0] == 2'd0) begin
        idle_cycles(1);
      end else if (r[1:0] == 2'd1) begin
        idle_cycles(2);
      end
    end
  endtask

  task automatic wait_drain();
    int waited;
    waited = 0;
    idle_cycles(1);
    while ((rd_idx < exp_q.size() || due_valid) && waited < DRAIN_LIMIT) begin
      @(posedge CLK);
      waited++;
    end
    if (rd_idx < exp_q.size() || due_valid) begin
      n_timeout++;
      $display("Timeout at %0t ns: bus cycles still waiting for a response", $time);
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Checks
  ////////////////////////////////////////////////////////////////////////////

  task automatic check_strobe(input string name, input logic exp, input logic act);
    n_checks++;
    if (act !== exp) begin
      n_strobe_err++;
      if (exp) begin
        $display("Error at %0t ns: %s missing after a bus cycle", $time, name);
      end else begin
        $display("Error at %0t ns: %s is %b with no bus cycle calling for it",
                 $time, name, act);
      end
    end
  endtask

  task automatic check_mem_req(input mem_req_t exp, input mem_req_t act);
    n_checks++;
    if (act !== exp) begin
      n_mem_err++;
      $write("Fail at %0t ns: mem_req exp addr=%h write=%b saveram=%b",
             $time, exp.addr, exp.write, exp.saveram);
      $display(", got addr=%h write=%b saveram=%b", act.addr, act.write, act.saveram);
    end
  endtask

  task automatic check_periph(input periph_e exp, input periph_e act);
    n_checks++;
    if (act !== exp) begin
      n_per_err++;
      $display("Fail at %0t ns: periph exp=%s got=%s", $time, exp.name(), act.name());
    end
  endtask

  // Response due one cycle after each bus_valid seen here
  always @(negedge CLK) begin
    if (rst_n) begin
      check_strobe("mem_req_valid", due_valid & due.mem_v, mem_req_valid);
      check_strobe("periph_valid", due_valid & due.per_v, periph_valid);
      if (due_valid && due.mem_v && mem_req_valid === 1'b1) begin
        check_mem_req(due.req, mem_req);
      end
      if (due_valid && due.per_v && periph_valid === 1'b1) begin
        check_periph(due.per, periph);
      end
      due_valid = 1'b0;
      if (bus_valid === 1'b1 && rd_idx < exp_q.size()) begin
        due       = exp_q[rd_idx];
        due_valid = 1'b1;
        rd_idx++;
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin
    cart_cfg_t c;
    rst_n        <= 1'b0;
    cfg_wr_valid <= 1'b0;
    cfg_wr       <= '0;
    bus_valid    <= 1'b0;
    bus          <= '0;
    model_cfg     = '0;  // HiROM with SaveRAM off
    repeat (3) @(posedge CLK);
    rst_n <= 1'b1;
    idle_cycles(6);  // Strobes must stay low
    run_cycles(20, 1'b0);  // Reset config
    // Every mapper plus an unknown code with SaveRAM on and off
    for (int m = 0; m < 4; m++) begin
      for (int s = 0; s < 2; s++) begin
        c              = random_cfg();
        c.mapper       = mapper_e'((m == 3) ? 3'd5 : 3'(m));
        c.sram_mask[0] = s[0];
        program_cfg(c);
        run_cycles(48, 1'b0);
      end
    end
    program_cfg(random_cfg());
    run_cycles(240, 1'b1);  // Config writes between cycles
    wait_drain();
    $display("Checks %0d, request errors %0d, periph errors %0d, strobe errors %0d, timeouts %0d",
             n_checks, n_mem_err, n_per_err, n_strobe_err, n_timeout);
    if (n_mem_err + n_per_err + n_strobe_err + n_timeout == 0) begin
      $display("=== PASS ===");
    end else begin
      $display("=== FAIL ===");
    end
    $finish;
  end

endmodule

// File: verification/cart_top_props.sv
module cart_top_props (
  input logic CLK,
  input logic rst_n,
  input logic bus_valid,
  input logic mem_req_valid,
  input logic periph_valid
);
  timeunit 1ns;
  timeprecision 1ps;

  ////////////////////////////////////////////////////////////////////////////
  // Strobe protocol
  ////////////////////////////////////////////////////////////////////////////

  // Memory request one cycle behind its bus strobe
  a_mem_follows_bus: assert property (@(posedge CLK) disable iff (!rst_n)
    mem_req_valid |-> $past(bus_valid))
    else $error("mem_req_valid without a bus_valid one cycle earlier");

  a_periph_follows_bus: assert property (@(posedge CLK) disable iff (!rst_n)
    periph_valid |-> $past(bus_valid))
    else $error("periph_valid without a bus_valid one cycle earlier");

  a_strobes_known: assert property (@(posedge CLK) disable iff (!rst_n)
    !$isunknown({mem_req_valid, periph_valid}))
    else $error("mem_req_valid or periph_valid unknown out of reset");

endmodule

bind bus_cycle_ctrl cart_top_props u_props (
  .CLK           (CLK),
  .rst_n         (rst_n),
  .bus_valid     (bus_valid),
  .mem_req_valid (mem_req_valid),
  .periph_valid  (periph_valid)
);

// File: source/cart_top.sv
module cart_top
  import cart_cfg_pkg::*;
  import snes_bus_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  // MCU config port
  input  logic        cfg_wr_valid,
  input  cfg_wr_t     cfg_wr,
  // SNES bus
  input  logic        bus_valid,
  input  snes_cycle_t bus,
  // Memory side, no back-pressure
  output logic        mem_req_valid,
  output mem_req_t    mem_req,
  // Peripheral select
  output logic        periph_valid,
  output periph_e     periph
);

  cart_cfg_t cfg;  // Live mapping
  addr_dec_t dec;  // Combinational decode of bus

  ////////////////////////////////////////////////////////////////////////////
  // Instances
  ////////////////////////////////////////////////////////////////////////////

  mcu_cfg_regs u_cfg_regs (
    .CLK          (CLK),
    .rst_n        (rst_n),
    .cfg_wr_valid (cfg_wr_valid),
    .cfg_wr       (cfg_wr),
    .cfg          (cfg)
  );

  address u_address (
    .bus (bus),
    .cfg (cfg),
    .dec (dec)
  );

  // One cycle latency
  bus_cycle_ctrl u_bus_cycle (
    .CLK           (CLK),
    .rst_n         (rst_n),
    .bus_valid     (bus_valid),
    .bus           (bus),
    .dec           (dec),
    .mem_req_valid (mem_req_valid),
    .mem_req       (mem_req),
    .periph_valid  (periph_valid),
    .periph        (periph)
  );

endmodule

// File: source/bus_cycle_ctrl.sv
module bus_cycle_ctrl
  import snes_bus_pkg::*;
(
  input  logic        CLK,
  input  logic        rst_n,
  input  logic        bus_valid,      // Single-cycle SNES strobe
  input  snes_cycle_t bus,
  input  addr_dec_t   dec,            // Decode of the same cycle
  output logic        mem_req_valid,  // One per memory hit
  output mem_req_t    mem_req,
  output logic        periph_valid,
  output periph_e     periph
);

  mem_req_t req_nxt;
  periph_e  periph_nxt;
  logic     any_periph;

  ////////////////////////////////////////////////////////////////////////////
  // Next request and peripheral select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    req_nxt.addr    = dec.mem_addr;
    req_nxt.write   = bus.write;       // Straight from the bus
    req_nxt.saveram = dec.is_saveram;
  end

  // Fixed priority, msu highest
  always_comb begin
    if (dec.msu_en) begin
      periph_nxt = PERIPH_MSU;
    end else if (dec.r213f_en) begin
      periph_nxt = PERIPH_R213F;
    end else if (dec.obc1_en) begin
      periph_nxt = PERIPH_OBC1;
    end else if (dec.snescmd_en) begin
      periph_nxt = PERIPH_SNESCMD;
    end else begin
      periph_nxt = PERIPH_NONE;
    end
  end

  assign any_periph = dec.msu_en | dec.r213f_en | dec.obc1_en | dec.snescmd_en;

  ////////////////////////////////////////////////////////////////////////////
  // Strobes
  ////////////////////////////////////////////////////////////////////////////

  // Reloaded every edge so each strobe lasts one cycle
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      mem_req_valid <= 1'b0;
      periph_valid  <= 1'b0;
    end else begin
      mem_req_valid <= bus_valid & dec.rom_hit;
      periph_valid  <= bus_valid & any_periph;
    end
  end

  // Payload
  always_ff @(posedge CLK) begin
    if (bus_valid) begin
      mem_req <= req_nxt;
      periph  <= periph_nxt;  // NONE when nothing selected
    end
  end

endmodule

// File: source/address.sv
module address
  import cart_cfg_pkg::*;
  import snes_bus_pkg::*;
(
  input  snes_cycle_t bus,  // Cycle currently on the SNES bus
  input  cart_cfg_t   cfg,
  output addr_dec_t   dec   // Pure function of bus and cfg
);

  logic [ADDR_W-1:0] a;         // Shorthand for the A bus
  logic              is_rom;
  logic              hi_sram;   // HiROM/ExHiROM SaveRAM window
  logic              lo_sram;   // LoROM SaveRAM window
  logic              sram_win;  // Window of the selected mapper
  logic              is_saveram;
  logic [ADDR_W-1:0] sram_off;  // Offset into SaveRAM before masking
  logic [ADDR_W-1:0] rom_addr;  // ROM address before masking
  logic [ADDR_W-1:0] mem_addr;

  assign a = bus.addr;

  ////////////////////////////////////////////////////////////////////////////
  // Region windows
  ////////////////////////////////////////////////////////////////////////////

  // Upper half of 00-3F/80-BF, all of 40-7F/C0-FF
  assign is_rom = a[22] | a[15];

  // Banks 20-3F/A0-BF, offset 6000-7FFF
  assign hi_sram = ~a[22] & a[21] & (&a[14:13]) & ~a[15];

  // Banks 70-7D/F0-FD; upper half only for small ROMs
  assign lo_sram = (&a[22:20])
                   & (a[19:16] < 4'hE)
                   & (~a[15] | ~cfg.rom_mask[21]);

  ////////////////////////////////////////////////////////////////////////////
  // Mapper select
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    sram_win = 1'b0;  // Unknown mapper maps nothing
    sram_off = '0;
    rom_addr = '0;
    case (cfg.mapper)
      MAPPER_HIROM: begin
        sram_win = hi_sram;
        sram_off = {6'b0, a[20:16], a[12:0]};
        rom_addr = {1'b0, a[22:0]};
      end
      MAPPER_LOROM: begin
        sram_win = lo_sram;
        sram_off = {4'b0, a[20:16], a[14:0]};  // 32K pages
        rom_addr = {2'b0, a[22:16], a[14:0]};  // Drop A15
      end
      MAPPER_EXHIROM: begin
        sram_win = hi_sram;
        sram_off = {6'b0, a[20:16], a[12:0]};
        rom_addr = {1'b0, ~a[23], a[21:0]};    // Banks 80+ come first
      end
      default: begin
        sram_win = 1'b0;
      end
    endcase
  end

  assign is_saveram = cfg.sram_mask[0] & sram_win;  // Mask bit 0 enables SaveRAM

  // SaveRAM rebased above ROM
  assign mem_addr = is_saveram ? SAVERAM_BASE + (sram_off & cfg.sram_mask)
                               : rom_addr & cfg.rom_mask;

  ////////////////////////////////////////////////////////////////////////////
  // Decode result and peripheral enables
  ////////////////////////////////////////////////////////////////////////////

  always_comb begin
    dec.mem_addr    = mem_addr;
    dec.is_rom      = is_rom;
    dec.is_saveram  = is_saveram;
    dec.is_writable = is_saveram;           // Only SaveRAM takes writes
    dec.rom_hit     = is_rom | is_saveram;
    dec.msu_en      = cfg.features[FEAT_MSU1] & ~a[22]
                      & ((a[15:0] & MSU_WIN_MASK) == MSU_BASE);
    dec.r213f_en    = cfg.features[FEAT_213F] & (bus.pa == PA_213F);  // B bus
    dec.obc1_en     = cfg.features[FEAT_OBC1] & ~a[22] & (a[15:11] == OBC1_PAGE);
    dec.snescmd_en  = ~a[22] & (a[15:9] == SNESCMD_PAGE);  // Always on
  end

endmodule

// File: source/mcu_cfg_regs.sv
module mcu_cfg_regs
  import cart_cfg_pkg::*;
(
  input  logic      CLK,
  input  logic      rst_n,
  input  logic      cfg_wr_valid,  // One cycle per MCU write
  input  cfg_wr_t   cfg_wr,
  output cart_cfg_t cfg            // Live mapping config
);

  ////////////////////////////////////////////////////////////////////////////
  // Opcode decode
  ////////////////////////////////////////////////////////////////////////////

  logic ld_mapper;
  logic ld_rom_mask;
  logic ld_sram_mask;
  logic ld_features;

  // One field load per opcode
  always_comb begin
    ld_mapper    = 1'b0;
    ld_rom_mask  = 1'b0;
    ld_sram_mask = 1'b0;
    ld_features  = 1'b0;
    if (cfg_wr_valid) begin
      case (cfg_wr.op)
        CFG_OP_MAPPER:    ld_mapper    = 1'b1;
        CFG_OP_ROM_MASK:  ld_rom_mask  = 1'b1;
        CFG_OP_SRAM_MASK: ld_sram_mask = 1'b1;
        CFG_OP_FEATURES:  ld_features  = 1'b1;
        default:          ld_mapper    = 1'b0;
      endcase
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // Config fields
  ////////////////////////////////////////////////////////////////////////////

  // Zero config is HiROM with SaveRAM off
  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cfg.mapper <= MAPPER_HIROM;
    end else if (ld_mapper) begin
      cfg.mapper <= mapper_e'(cfg_wr.data[MAPPER_W-1:0]);  // Unknown codes kept
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cfg.rom_mask <= '0;
    end else if (ld_rom_mask) begin
      cfg.rom_mask <= cfg_wr.data[MASK_W-1:0];
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cfg.sram_mask <= '0;  // Bit 0 low, no SaveRAM
    end else if (ld_sram_mask) begin
      cfg.sram_mask <= cfg_wr.data[MASK_W-1:0];
    end
  end

  always_ff @(posedge CLK or negedge rst_n) begin
    if (!rst_n) begin
      cfg.features <= '0;  // All peripherals off
    end else if (ld_features) begin
      cfg.features <= cfg_wr.data[FEAT_W-1:0];  // Low byte only
    end
  end

endmodule

// File: source/snes_bus_pkg.sv
package snes_bus_pkg;

  localparam int ADDR_W = 24;  // SNES A bus and memory address
  localparam int PA_W   = 8;   // B bus peripheral address

  // Peripheral windows
  localparam logic [15:0] MSU_BASE     = 16'h2000;  // 2000..2007
  localparam logic [15:0] MSU_WIN_MASK = 16'hFFF8;
  localparam logic [PA_W-1:0] PA_213F  = 8'h3F;
  localparam logic [4:0]  OBC1_PAGE    = 5'b01111;    // Bits 15..11
  localparam logic [6:0]  SNESCMD_PAGE = 7'b0010101;  // Bits 15..9

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic [PA_W-1:0]   pa;
    logic              write;  // High on SNES write
  } snes_cycle_t;

  // Listed in select priority, msu first
  typedef enum logic [2:0] {
    PERIPH_NONE    = 3'd0,
    PERIPH_MSU     = 3'd1,
    PERIPH_R213F   = 3'd2,
    PERIPH_OBC1    = 3'd3,
    PERIPH_SNESCMD = 3'd4
  } periph_e;

  typedef struct packed {
    logic [ADDR_W-1:0] mem_addr;  // Masked, SaveRAM already rebased
    logic              is_rom;
    logic              is_saveram;
    logic              is_writable;
    logic              rom_hit;   // Any memory access
    logic              msu_en;
    logic              r213f_en;
    logic              obc1_en;
    logic              snescmd_en;
  } addr_dec_t;

  typedef struct packed {
    logic [ADDR_W-1:0] addr;
    logic              write;
    logic              saveram;
  } mem_req_t;

endpackage

// File: source/cart_cfg_pkg.sv
package cart_cfg_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // Widths and constants
  ////////////////////////////////////////////////////////////////////////////

  localparam int CFG_DATA_W = 24;  // Payload of one MCU write
  localparam int MASK_W     = 24;  // ROM and SaveRAM mask width
  localparam int MAPPER_W   = 3;
  localparam int FEAT_W     = 8;

  // Feature bit positions
  localparam int FEAT_MSU1 = 3;
  localparam int FEAT_213F = 4;
  localparam int FEAT_OBC1 = 5;

  // SaveRAM lives at the top of the memory map
  localparam logic [MASK_W-1:0] SAVERAM_BASE = 24'hE00000;

  ////////////////////////////////////////////////////////////////////////////
  // Types
  ////////////////////////////////////////////////////////////////////////////

  // Codes 3..7 select no mapping at all
  typedef enum logic [MAPPER_W-1:0] {
    MAPPER_HIROM   = 3'd0,
    MAPPER_LOROM   = 3'd1,
    MAPPER_EXHIROM = 3'd2
  } mapper_e;

  typedef enum logic [1:0] {
    CFG_OP_MAPPER    = 2'd0,
    CFG_OP_ROM_MASK  = 2'd1,
    CFG_OP_SRAM_MASK = 2'd2,
    CFG_OP_FEATURES  = 2'd3
  } cfg_op_e;

  typedef struct packed {
    cfg_op_e               op;    // Which field to load
    logic [CFG_DATA_W-1:0] data;  // Truncated to field width
  } cfg_wr_t;

  typedef struct packed {
    mapper_e           mapper;
    logic [MASK_W-1:0] rom_mask;
    logic [MASK_W-1:0] sram_mask;  // Bit 0 doubles as SaveRAM enable
    logic [FEAT_W-1:0] features;
  } cart_cfg_t;

endpackage
